// ==== Makefile ====
# Verilator build and run for the host board testbench

SIM      = verilator
TOP      = hostBoardTb
RTL_TOP  = hostBoard
FILELIST = sources.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS = --lint-only -Wall --timing
PASS_MSG = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== bench/hostBoardTb.sv ====
/*
 * Testbench for the host board: clock, reset, Z80 bus-cycle tasks,
 * random RAM and serial stimulus, reference model, txd decoder,
 * compare tasks and a cycle-count watchdog
 */
`timescale 1ns/100ps

module hostBoardTb;

    // Test lengths
    localparam int NumRamWrites = 48;
    localparam int NumUnmapped  = 6;
    localparam int NumTx        = 8;
    localparam int NumFixed     = 6;
    // Bus cycles per section with the polls of one frame counted once
    localparam int BusCycles = 2 * NumRamWrites + 3 * NumUnmapped + 3 * NumTx + 6 + 2 * NumFixed;
    localparam int Frames    = NumTx + 1;
    localparam int TimeoutCycles = 4 * (BusCycles * 3 + Frames * 10 * hostPkg::ClocksPerBit);

    logic        clk;
    logic        reset;
    logic [15:0] address;
    logic [7:0]  dataIn;
    logic        nMreq;
    logic        nIorq;
    logic        nRd;
    logic        nWr;
    logic        nM1;
    logic [7:0]  dataOut;
    logic        dataOutEnable;
    logic        txd;

    int seed = 32'h8d34_3866;
    int cycleCount;
    // RAM reference model where only written cells are compared
    logic [7:0] model [0:(2**hostPkg::RamAddrBits)-1];
    logic [7:0] expBytes[$];
    logic [7:0] rxBytes[$];
    hostPkg::uartState txState;

    hostBoard u_hostBoard (
        .clk           (clk),
        .reset         (reset),
        .address       (address),
        .dataIn        (dataIn),
        .nMreq         (nMreq),
        .nIorq         (nIorq),
        .nRd           (nRd),
        .nWr           (nWr),
        .nM1           (nM1),
        .dataOut       (dataOut),
        .dataOutEnable (dataOutEnable),
        .txd           (txd)
    );

    // Transmitter state for the failure messages
    assign txState = u_hostBoard.u_uartPort.state;

    always #4 clk = ~clk;

    //~~~~~~~~~~~~~~~~~~~~
    // Error and compare tasks
    //~~~~~~~~~~~~~~~~~~~~
    task automatic reportError(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkRead(input hostPkg::busCycle kind, input logic [15:0] addr,
                             input logic [7:0] got, input logic [7:0] exp, input logic en);
        if (en !== 1'b1)
            reportError($sformatf("FAIL %0t: %s at %h without dataOutEnable",
                                  $time, kind.name(), addr));
        if (got !== exp)
            reportError($sformatf("FAIL %0t: %s at %h returned %h, expected %h",
                                  $time, kind.name(), addr, got, exp));
    endtask

    task automatic checkSerial(input int idx, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            reportError($sformatf("FAIL %0t: serial byte %0d was %h, expected %h, tx in %s",
                                  $time, idx, got, exp, txState.name()));
    endtask

    task automatic checkStatus(input string what, input logic got, input logic exp);
        if (got !== exp)
            reportError($sformatf("FAIL %0t: %s was %b, expected %b, tx in %s",
                                  $time, what, got, exp, txState.name()));
    endtask

    //~~~~~~~~~~~~~~~~~~~~
    // Bus cycles
    //~~~~~~~~~~~~~~~~~~~~
    // Strobes low for two edges, data taken after the second, then one idle edge
    task automatic runCycle(input hostPkg::busCycle kind, input logic [15:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata,
                            output logic en);
        @(posedge clk);
        address <= addr;
        dataIn  <= wdata;
        nMreq   <= !(kind == hostPkg::cycleMemRead || kind == hostPkg::cycleMemWrite);
        nIorq   <= !(kind == hostPkg::cycleIoRead || kind == hostPkg::cycleIoWrite ||
                     kind == hostPkg::cycleIntAck);
        nRd     <= !(kind == hostPkg::cycleMemRead || kind == hostPkg::cycleIoRead);
        nWr     <= !(kind == hostPkg::cycleMemWrite || kind == hostPkg::cycleIoWrite);
        nM1     <= !(kind == hostPkg::cycleIntAck);
        // This edge saw the idle gap of the previous cycle
        #1 checkStatus("dataOutEnable between cycles", dataOutEnable, 1'b0);
        @(posedge clk);
        @(posedge clk);
        nMreq <= 1'b1;
        nIorq <= 1'b1;
        nRd   <= 1'b1;
        nWr   <= 1'b1;
        nM1   <= 1'b1;
        #1;
        rdata = dataOut;
        en    = dataOutEnable;
    endtask

    task automatic memRead(input logic [15:0] addr, output logic [7:0] rdata, output logic en);
        runCycle(hostPkg::cycleMemRead, addr, 8'h00, rdata, en);
    endtask

    task automatic memWrite(input logic [15:0] addr, input logic [7:0] wdata);
        logic [7:0] unused;
        logic enUnused;
        runCycle(hostPkg::cycleMemWrite, addr, wdata, unused, enUnused);
    endtask

    task automatic ioRead(input logic [15:0] addr, output logic [7:0] rdata, output logic en);
        runCycle(hostPkg::cycleIoRead, addr, 8'h00, rdata, en);
    endtask

    task automatic ioWrite(input logic [15:0] addr, input logic [7:0] wdata);
        logic [7:0] unused;
        logic enUnused;
        runCycle(hostPkg::cycleIoWrite, addr, wdata, unused, enUnused);
    endtask

    task automatic intAck(input logic [15:0] addr, output logic [7:0] rdata, output logic en);
        runCycle(hostPkg::cycleIntAck, addr, 8'h00, rdata, en);
    endtask

    // Poll 02xx until idle and expect 00h from one more read
    task automatic waitNotBusy();
        logic [7:0] rd;
        logic en;
        logic [15:0] addr;
        addr = {8'h02, 8'($unsigned($random(seed)))};
        do begin
            ioRead(addr, rd, en);
        end while (rd[0] === 1'b1);
        ioRead(addr, rd, en);
        checkRead(hostPkg::cycleIoRead, addr, rd, 8'h00, en);
    endtask

    //~~~~~~~~~~~~~~~~~~~~
    // Serial line decoder
    //~~~~~~~~~~~~~~~~~~~~
    // Samples on falling clock edges in the middle of each bit
    initial begin : serialMonitor
        logic [7:0] rxByte;
        wait (reset == 1'b0);
        forever begin
            @(negedge txd);
            repeat (hostPkg::ClocksPerBit / 2) @(negedge clk);
            if (txd !== 1'b0)
                reportError("Serial decoder saw a start bit shorter than half a bit");
            for (int i = 0; i < 8; i++) begin
                repeat (hostPkg::ClocksPerBit) @(negedge clk);
                rxByte[i] = txd;
            end
            repeat (hostPkg::ClocksPerBit) @(negedge clk);
            if (txd !== 1'b1)
                reportError("Serial decoder found no stop bit after the data bits");
            rxBytes.push_back(rxByte);
        end
    end

    // Watchdog
    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d clock cycles, the test did not finish", cycleCount);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    //~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    //~~~~~~~~~~~~~~~~~~~~
    initial begin : mainSequence
        logic [7:0] rd;
        logic [7:0] wd;
        logic [7:0] port;
        logic en;
        logic [13:0] ramA;
        logic [15:0] addr;
        logic [13:0] writtenAddrs[$];
        logic [13:0] pending[$];
        int idx;
        clk     = 1'b0;
        reset   = 1'b1;
        address = 16'h0000;
        dataIn  = 8'h00;
        nMreq   = 1'b1;
        nIorq   = 1'b1;
        nRd     = 1'b1;
        nWr     = 1'b1;
        nM1     = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        #1 checkStatus("txd after reset", txd, 1'b1);

        // RAM round trip with reads in shuffled order
        for (int n = 0; n < NumRamWrites; n++) begin
            ramA = 14'($unsigned($random(seed)));
            wd   = 8'($unsigned($random(seed)));
            memWrite({2'b00, ramA}, wd);
            model[ramA] = wd;
            writtenAddrs.push_back(ramA);
        end
        pending = writtenAddrs;
        while (pending.size() > 0) begin
            idx  = int'($unsigned($random(seed)) % pending.size());
            ramA = pending[idx];
            pending.delete(idx);
            memRead({2'b00, ramA}, rd, en);
            checkRead(hostPkg::cycleMemRead, {2'b00, ramA}, rd, model[ramA], en);
        end

        // Unmapped memory reads HALT and ignores writes
        for (int n = 0; n < NumUnmapped; n++) begin
            addr = 16'($unsigned($random(seed)) % 32'hC000 + 32'h4000);
            memRead(addr, rd, en);
            checkRead(hostPkg::cycleMemRead, addr, rd, 8'h76, en);
            idx  = int'($unsigned($random(seed)) % writtenAddrs.size());
            ramA = writtenAddrs[idx];
            addr = {2'($unsigned($random(seed)) % 3 + 1), ramA};
            memWrite(addr, ~model[ramA]);
            memRead({2'b00, ramA}, rd, en);
            checkRead(hostPkg::cycleMemRead, {2'b00, ramA}, rd, model[ramA], en);
        end

        // Serial transmit
        for (int n = 0; n < NumTx; n++) begin
            waitNotBusy();
            wd = 8'($unsigned($random(seed)));
            ioWrite({8'h00, 8'($unsigned($random(seed)))}, wd);
            expBytes.push_back(wd);
        end

        // Busy right after a write and the second write dropped
        waitNotBusy();
        wd = 8'($unsigned($random(seed)));
        ioWrite({8'h00, 8'($unsigned($random(seed)))}, wd);
        expBytes.push_back(wd);
        addr = {8'h02, 8'($unsigned($random(seed)))};
        ioRead(addr, rd, en);
        checkRead(hostPkg::cycleIoRead, addr, rd, 8'h01, en);
        ioWrite({8'h00, 8'($unsigned($random(seed)))}, ~wd);
        waitNotBusy();

        // Interrupt vector and idle I/O answer
        for (int n = 0; n < NumFixed; n++) begin
            addr = 16'($unsigned($random(seed)));
            intAck(addr, rd, en);
            checkRead(hostPkg::cycleIntAck, addr, rd, 8'h80, en);
            do begin
                port = 8'($unsigned($random(seed)));
            end while (port == 8'h02);
            addr = {port, 8'($unsigned($random(seed)))};
            ioRead(addr, rd, en);
            checkRead(hostPkg::cycleIoRead, addr, rd, 8'hFF, en);
        end

        // Every accepted byte on txd, in order, and nothing else
        if (rxBytes.size() != expBytes.size())
            reportError($sformatf("Serial decoder received %0d bytes on txd but %0d were sent",
                                  rxBytes.size(), expBytes.size()));
        foreach (expBytes[i]) begin
            checkSerial(i, rxBytes[i], expBytes[i]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== logic/busDecoder.sv ====
/*
 * Z80 bus cycle decoder: strobe classification,
 * RAM and serial write enables, and the registered
 * read data combiner with its output enable
 */
`timescale 1ns/100ps

module busDecoder (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [15:0]                      address,
    input  logic [7:0]                       dataIn,
    input  logic                             nMreq,
    input  logic                             nIorq,
    input  logic                             nRd,
    input  logic                             nWr,
    input  logic                             nM1,
    input  logic [7:0]                       ramQ,
    input  logic                             busy,
    output logic                             ramWrite,
    output logic [hostPkg::RamAddrBits-1:0]  ramAddr,
    output logic                             txWrite,
    output logic [7:0]                       txData,
    output logic [7:0]                       dataOut,
    output logic                             dataOutEnable
);

    hostPkg::busCycle cycle;
    hostPkg::busCycle cycleReg;
    logic ramHit;
    logic statusHit;
    logic ramHitReg;
    logic statusHitReg;
    logic readCycle;
    logic readCycleReg;

    //~~~~~~~~~~~~~~~~~~~~
    // Cycle classification
    //~~~~~~~~~~~~~~~~~~~~
    // Interrupt acknowledge wins over plain I/O as on the Z80
    always_comb begin
        cycle = hostPkg::cycleIdle;
        if (!nIorq && !nM1) begin
            cycle = hostPkg::cycleIntAck;
        end else if (!nIorq && !nRd) begin
            cycle = hostPkg::cycleIoRead;
        end else if (!nIorq && !nWr) begin
            cycle = hostPkg::cycleIoWrite;
        end else if (!nMreq && !nRd) begin
            cycle = hostPkg::cycleMemRead;
        end else if (!nMreq && !nWr) begin
            cycle = hostPkg::cycleMemWrite;
        end
    end

    // Address decode
    assign ramHit    = (address[15:hostPkg::RamAddrBits] == hostPkg::RamRegion);
    assign statusHit = (address[15:8] == hostPkg::UartStatusPort);

    assign readCycle = (cycle == hostPkg::cycleMemRead) ||
                       (cycle == hostPkg::cycleIoRead)  ||
                       (cycle == hostPkg::cycleIntAck);
    assign readCycleReg = (cycleReg == hostPkg::cycleMemRead) ||
                          (cycleReg == hostPkg::cycleIoRead)  ||
                          (cycleReg == hostPkg::cycleIntAck);

    // Writes act on every edge of the cycle while address and data are stable
    assign ramWrite = (cycle == hostPkg::cycleMemWrite) && ramHit;
    assign ramAddr  = address[hostPkg::RamAddrBits-1:0];
    assign txWrite  = (cycle == hostPkg::cycleIoWrite) &&
                      (address[15:8] == hostPkg::UartTxPort);
    assign txData   = dataIn;

    //~~~~~~~~~~~~~~~~~~~~
    // Read path
    //~~~~~~~~~~~~~~~~~~~~
    // Selection stage lines up with the registered RAM output
    always_ff @(posedge clk) begin
        if (reset) begin
            cycleReg      <= hostPkg::cycleIdle;
            ramHitReg     <= 1'b0;
            statusHitReg  <= 1'b0;
            dataOutEnable <= 1'b0;
        end else begin
            cycleReg     <= cycle;
            ramHitReg    <= ramHit;
            statusHitReg <= statusHit;
            // Rises on the second edge of a read and drops on the first idle edge
            dataOutEnable <= readCycle && readCycleReg;
        end
    end

    // Data combiner
    always_ff @(posedge clk) begin
        case (cycleReg)
            hostPkg::cycleMemRead: dataOut <= ramHitReg ? ramQ : hostPkg::HaltOpcode;
            hostPkg::cycleIoRead:  dataOut <= statusHitReg ? {7'b0, busy} : hostPkg::IdleIoData;
            hostPkg::cycleIntAck:  dataOut <= hostPkg::IntVector;
            default:               dataOut <= hostPkg::IdleIoData;
        endcase
    end

    // Master must never read and write at once
    noReadWithWrite: assert property (@(posedge clk) disable iff (reset) !(!nRd && !nWr));

endmodule

// ==== logic/hostBoard.sv ====
/*
 * Host board top: bus decoder, 16K RAM
 * and the serial transmitter on one clock
 */
`timescale 1ns/100ps

module hostBoard (
    input  logic        clk,
    input  logic        reset,
    input  logic [15:0] address,
    input  logic [7:0]  dataIn,
    input  logic        nMreq,
    input  logic        nIorq,
    input  logic        nRd,
    input  logic        nWr,
    input  logic        nM1,
    output logic [7:0]  dataOut,
    output logic        dataOutEnable,
    output logic        txd
);

    // Decoder to RAM
    logic                            ramWrite;
    logic [hostPkg::RamAddrBits-1:0] ramAddr;
    logic [7:0]                      ramQ;

    // Decoder to serial port
    logic       txWrite;
    logic [7:0] txData;
    logic       busy;

    //~~~~~~~~~~~~~~~~~~~~
    // Bus decoder
    //~~~~~~~~~~~~~~~~~~~~
    busDecoder u_busDecoder (
        .clk           (clk),
        .reset         (reset),
        .address       (address),
        .dataIn        (dataIn),
        .nMreq         (nMreq),
        .nIorq         (nIorq),
        .nRd           (nRd),
        .nWr           (nWr),
        .nM1           (nM1),
        .ramQ          (ramQ),
        .busy          (busy),
        .ramWrite      (ramWrite),
        .ramAddr       (ramAddr),
        .txWrite       (txWrite),
        .txData        (txData),
        .dataOut       (dataOut),
        .dataOutEnable (dataOutEnable)
    );

    //~~~~~~~~~~~~~~~~~~~~
    // RAM 0000-3FFF
    //~~~~~~~~~~~~~~~~~~~~
    memoryBlock u_memoryBlock (
        .clk      (clk),
        .ramWrite (ramWrite),
        .ramAddr  (ramAddr),
        .dataIn   (dataIn),
        .ramQ     (ramQ)
    );

    //~~~~~~~~~~~~~~~~~~~~
    // Serial port, I/O 00xx and 02xx
    //~~~~~~~~~~~~~~~~~~~~
    uartPort u_uartPort (
        .clk     (clk),
        .reset   (reset),
        .txWrite (txWrite),
        .txData  (txData),
        .busy    (busy),
        .txd     (txd)
    );

endmodule

// ==== logic/hostPkg.sv ====
/*
 * Shared constants of the host board peripherals:
 * memory map, fixed read answers, serial timing,
 * and the enums for bus cycles and transmitter states
 */
package hostPkg;

    //~~~~~~~~~~~~~~~~~~~~
    // Memory map
    //~~~~~~~~~~~~~~~~~~~~
    // 16K RAM at 0000-3FFF
    localparam int RamAddrBits = 14;
    // Top address bits that select the RAM
    localparam logic [15-RamAddrBits:0] RamRegion = '0;

    // Read answers for everything that is not RAM or status
    localparam logic [7:0] HaltOpcode = 8'h76;
    localparam logic [7:0] IntVector  = 8'h80;
    localparam logic [7:0] IdleIoData = 8'hFF;

    //~~~~~~~~~~~~~~~~~~~~
    // Serial port
    //~~~~~~~~~~~~~~~~~~~~
    // Upper address byte of the I/O ports
    localparam logic [7:0] UartTxPort     = 8'h00;
    localparam logic [7:0] UartStatusPort = 8'h02;
    // Bit period in clocks, kept short for simulation
    localparam int ClocksPerBit = 8;

    // Z80 bus cycle as seen on the strobes
    typedef enum logic [2:0] {
        cycleIdle,
        cycleMemRead,
        cycleMemWrite,
        cycleIoRead,
        cycleIoWrite,
        cycleIntAck
    } busCycle;

    // 8N1 transmitter states
    typedef enum logic [1:0] {
        txIdle,
        txStart,
        txData,
        txStop
    } uartState;

endpackage

// ==== logic/memoryBlock.sv ====
/*
 * 16K byte RAM, synchronous write, registered read
 */
`timescale 1ns/100ps

module memoryBlock (
    input  logic                             clk,
    input  logic                             ramWrite,
    input  logic [hostPkg::RamAddrBits-1:0]  ramAddr,
    input  logic [7:0]                       dataIn,
    output logic [7:0]                       ramQ
);

    // Byte array, maps onto block RAM
    logic [7:0] mem [0:(2**hostPkg::RamAddrBits)-1];

    //~~~~~~~~~~~~~~~~~~~~
    // Write port
    //~~~~~~~~~~~~~~~~~~~~
    // Repeated writes within one cycle store the same byte
    always_ff @(posedge clk) begin
        if (ramWrite) begin
            mem[ramAddr] <= dataIn;
        end
    end

    //~~~~~~~~~~~~~~~~~~~~
    // Read port
    //~~~~~~~~~~~~~~~~~~~~
    // Old data on a same-edge write, read-first behaviour
    always_ff @(posedge clk) begin
        ramQ <= mem[ramAddr];
    end

    // Write address must be known
    knownWriteAddr: assert property (@(posedge clk) ramWrite |-> !$isunknown(ramAddr));

endmodule

// ==== logic/uartPort.sv ====
/*
 * Transmit-only 8N1 serial port:
 * write edge detect, byte latch, state machine
 * with bit and clock counters, and the busy flag
 */
`timescale 1ns/100ps

module uartPort (
    input  logic       clk,
    input  logic       reset,
    input  logic       txWrite,
    input  logic [7:0] txData,
    output logic       busy,
    output logic       txd
);

    hostPkg::uartState state;
    logic txWriteDly;
    logic txAccept;
    logic bitDone;
    logic [$clog2(hostPkg::ClocksPerBit)-1:0] clkCount;
    logic [2:0] bitCount;
    logic [7:0] shifter;

    //~~~~~~~~~~~~~~~~~~~~
    // Write acceptance
    //~~~~~~~~~~~~~~~~~~~~
    // Only the first edge of a write strobe counts
    // Writes during a frame are dropped
    assign txAccept = txWrite && !txWriteDly && !busy;

    // Last clock of the current bit period
    assign bitDone = (int'(clkCount) == hostPkg::ClocksPerBit - 1);

    //~~~~~~~~~~~~~~~~~~~~
    // Transmit FSM
    //~~~~~~~~~~~~~~~~~~~~
    // txd follows the state one edge later, so each bit lasts ClocksPerBit
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= hostPkg::txIdle;
            txWriteDly <= 1'b0;
            busy       <= 1'b0;
            txd        <= 1'b1;
            clkCount   <= '0;
            bitCount   <= '0;
        end else begin
            txWriteDly <= txWrite;
            // Busy trails the state by one edge, like txd
            busy <= txAccept || (state != hostPkg::txIdle);
            case (state)
                hostPkg::txIdle: begin
                    txd <= 1'b1;
                    if (txAccept) begin
                        state    <= hostPkg::txStart;
                        clkCount <= '0;
                    end
                end
                hostPkg::txStart: begin
                    txd      <= 1'b0;
                    clkCount <= clkCount + 1'b1;
                    if (bitDone) begin
                        clkCount <= '0;
                        bitCount <= '0;
                        state    <= hostPkg::txData;
                    end
                end
                hostPkg::txData: begin
                    txd      <= shifter[0];
                    clkCount <= clkCount + 1'b1;
                    if (bitDone) begin
                        clkCount <= '0;
                        bitCount <= bitCount + 1'b1;
                        // Eighth bit done
                        if (bitCount == 3'd7) begin
                            state <= hostPkg::txStop;
                        end
                    end
                end
                hostPkg::txStop: begin
                    txd      <= 1'b1;
                    clkCount <= clkCount + 1'b1;
                    if (bitDone) begin
                        clkCount <= '0;
                        state    <= hostPkg::txIdle;
                    end
                end
                default: begin
                    state <= hostPkg::txIdle;
                end
            endcase
        end
    end

    // Byte shifter, LSB goes out first
    always_ff @(posedge clk) begin
        if (txAccept) begin
            shifter <= txData;
        end else if (state == hostPkg::txData && bitDone) begin
            shifter <= {1'b0, shifter[7:1]};
        end
    end

    // Line idles high between frames
    idleLineHigh: assert property (@(posedge clk) disable iff (reset)
        state == hostPkg::txIdle |-> txd);

endmodule

// ==== sources.f ====
logic/hostPkg.sv
logic/busDecoder.sv
logic/memoryBlock.sv
logic/uartPort.sv
logic/hostBoard.sv
bench/hostBoardTb.sv
